/* src/st_mem_pkg.sv */
// shared widths and types; word addresses are byte address bits 23:1, mem size codes 6/7 unused
`default_nettype none

package st_mem_pkg;

	parameter int ADDR_W = 23; // word address, byte bits 23:1
	parameter int DATA_W = 16;

	// ram size as coded in system control word bits 3:1
	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,
		MEM_14M  = 3'd5
	} mem_size_e;

	typedef struct packed {
		mem_size_e mem_size;
		logic      ste;       // ste or mega ste
		logic      steroids;  // both model bits set
		logic      viking_en; // hi-res card usable
	} sys_cfg_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic              rd;
		logic              wr;
		logic              uds;
		logic              lds;
	} mmu_req_t;

	// blitter bus master, always full word
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic              rd;
		logic              wr;
	} bm_req_t;

	typedef struct packed {
		logic [ADDR_W:0]   addr; // msb tied low
		logic [DATA_W-1:0] din;
		logic              oe;
		logic              we;
		logic              uds;
		logic              lds;
	} sdram_cmd_t;

	typedef enum logic [1:0] {PRE = 2'd0, CPU = 2'd1, VIDEO = 2'd2, IDLE = 2'd3} slot_e;

	typedef enum logic [1:0] {OWN_MMU, OWN_BLIT, OWN_DL, OWN_VID} owner_e;

	// top six word address bits of the hi-res card window
	parameter logic [5:0] VIKING_BASE_ST = 6'b110000; // $c00000
	parameter logic [5:0] VIKING_BASE_HI = 6'b111010; // $e80000, steroids

endpackage

`default_nettype wire

/* src/st_bus_ctrl.sv */
// SLOT_DIV must be 2 or more; upload host must hold dl_addr/dl_data stable from req until ack
`timescale 1ns/10ps
`default_nettype none

module st_bus_ctrl
	import st_mem_pkg::*;
#(
	parameter int SLOT_DIV = 4 // clocks per bus slot
) (
	input  wire         clk_32,
	input  wire         xsint,
	input  wire  [31:0] system_ctrl_i,
	input  wire         dl_active_i,
	input  wire         dl_req_i,
	input  wire         bm_has_bus_i,
	input  wire         vid_read_i,
	input  wire         viking_active_i,
	output sys_cfg_t    cfg_o,
	output slot_e       slot_o,
	output logic        slot_stb_o,
	output owner_e      owner_o,
	output logic        dl_wr_o,
	output logic        dl_ack_o
);

	localparam int DIV_W = $clog2(SLOT_DIV + 1);

	logic [DIV_W-1:0] div_cnt; // prescaler
	slot_e            slot_q;

	// configuration decode, purely combinational
	always_comb begin
		cfg_o.mem_size  = mem_size_e'(system_ctrl_i[3:1]);
		cfg_o.ste       = system_ctrl_i[23] | system_ctrl_i[24];
		cfg_o.steroids  = system_ctrl_i[23] & system_ctrl_i[24]; // ste on steroids
		// card needs ram up to 8M, steroids moves it above 14M
		cfg_o.viking_en = (system_ctrl_i[28] && (cfg_o.mem_size <= MEM_8M)) ||
		                  cfg_o.steroids;
	end

	assign slot_stb_o = (div_cnt == DIV_W'(SLOT_DIV - 1)); // last clock of slot
	assign slot_o     = slot_q;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			div_cnt <= '0;
			slot_q  <= PRE;
		end else if (slot_stb_o) begin
			div_cnt <= '0;
			slot_q  <= slot_e'(slot_q + 2'd1); // idle wraps to pre
		end else begin
			div_cnt <= div_cnt + DIV_W'(1);
		end
	end

	// upload req/ack, ack itself is the state bit
	// one write per request, only on a cpu slot strobe
	assign dl_wr_o = dl_active_i && dl_req_i && !dl_ack_o &&
	                 (slot_q == CPU) && slot_stb_o;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			dl_ack_o <= 1'b0;
		else if (dl_wr_o)
			dl_ack_o <= 1'b1; // same edge as the write command
		else if (dl_ack_o && !dl_req_i)
			dl_ack_o <= 1'b0; // host released req
	end

	// bus owner by slot and priority
	always_comb begin
		owner_o = OWN_MMU;
		case (slot_q)
			CPU: begin
				if (dl_active_i)
					owner_o = OWN_DL;   // upload beats blitter
				else if (bm_has_bus_i)
					owner_o = OWN_BLIT;
			end
			VIDEO: if (viking_active_i && vid_read_i) owner_o = OWN_VID;
			default: owner_o = OWN_MMU; // pre and idle
		endcase
	end

	// ack only ever answers a pending request
	a_ack_needs_req: assert property (@(posedge clk_32) disable iff (!xsint)
		$rose(dl_ack_o) |-> $past(dl_req_i));

	// upload write lands in a cpu slot owned by the upload
	a_dl_wr_cpu: assert property (@(posedge clk_32) disable iff (!xsint)
		dl_wr_o |-> (slot_o == CPU) && (owner_o == OWN_DL));

endmodule

`default_nettype wire

/* src/st_ram_window.sv */
// command is registered one clock after its inputs; mem size codes 6/7 block all mmu access
`timescale 1ns/10ps
`default_nettype none

module st_ram_window
	import st_mem_pkg::*;
(
	input  wire               clk_32,
	input  wire               xsint,
	input  sys_cfg_t          cfg_i,
	input  owner_e            owner_i,
	input  wire               dl_wr_i,
	input  mmu_req_t          mmu_i,
	input  bm_req_t           bm_i,
	input  wire  [ADDR_W-1:0] vid_addr_i,
	input  wire  [ADDR_W-1:0] dl_addr_i,
	input  wire  [DATA_W-1:0] dl_data_i,
	output sdram_cmd_t        sdram_o
);

	logic              ram_ok; // mmu address inside configured ram
	sdram_cmd_t        nxt;
	logic [ADDR_W:0]   addr_q;
	logic [DATA_W-1:0] din_q;
	logic              oe_q, we_q;
	logic              uds_q, lds_q;

	// size windows on word address, a[22] is byte bit 23
	always_comb begin
		case (cfg_i.mem_size)
			MEM_512K: ram_ok = (mmu_i.addr[22:18] == 5'b00000);
			MEM_1M:   ram_ok = (mmu_i.addr[22:19] == 4'b0000);
			MEM_2M:   ram_ok = (mmu_i.addr[22:20] == 3'b000);
			MEM_4M:   ram_ok = (mmu_i.addr[22:21] == 2'b00);
			MEM_8M:   ram_ok = !mmu_i.addr[22];
			MEM_14M:  ram_ok = !(&mmu_i.addr[22:20]); // all but $e00000 up
			default:  ram_ok = 1'b0;
		endcase
	end

	always_comb begin
		nxt.addr = {1'b0, mmu_i.addr};
		nxt.din  = mmu_i.data;
		nxt.oe   = mmu_i.rd & ram_ok; // out of range still passes addr/data
		nxt.we   = mmu_i.wr & ram_ok;
		nxt.uds  = mmu_i.uds;
		nxt.lds  = mmu_i.lds;
		case (owner_i)
			OWN_DL: begin
				nxt.addr = {1'b0, dl_addr_i};
				nxt.din  = dl_data_i;
				nxt.oe   = 1'b0;
				nxt.we   = dl_wr_i; // only on the granted strobe
				nxt.uds  = 1'b1;
				nxt.lds  = 1'b1;
			end
			OWN_BLIT: begin
				nxt.addr = {1'b0, bm_i.addr};
				nxt.din  = bm_i.data;
				nxt.oe   = bm_i.rd;
				nxt.we   = bm_i.wr;
				nxt.uds  = 1'b1; // blitter is word only
				nxt.lds  = 1'b1;
			end
			OWN_VID: begin
				nxt.addr = {1'b0, vid_addr_i};
				nxt.din  = '0;
				nxt.oe   = 1'b1; // video fetch
				nxt.we   = 1'b0;
				nxt.uds  = 1'b1;
				nxt.lds  = 1'b1;
			end
			default: ; // mmu, set above
		endcase
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			oe_q <= 1'b0;
			we_q <= 1'b0;
		end else begin
			oe_q <= nxt.oe;
			we_q <= nxt.we;
		end
	end

	// payload follows without reset
	always_ff @(posedge clk_32) begin
		addr_q <= nxt.addr;
		din_q  <= nxt.din;
		uds_q  <= nxt.uds;
		lds_q  <= nxt.lds;
	end

	assign sdram_o = '{addr: addr_q, din: din_q, oe: oe_q, we: we_q, uds: uds_q, lds: lds_q};

	// read and write never issued in one command
	a_no_rd_wr: assert property (@(posedge clk_32) disable iff (!xsint)
		!(sdram_o.oe && sdram_o.we));

endmodule

`default_nettype wire

/* src/st_rom_map.sv */
// tos size is learned from upload addresses only; rom_addr_o is combinational
`timescale 1ns/10ps
`default_nettype none

module st_rom_map
	import st_mem_pkg::*;
(
	input  wire               clk_32,
	input  wire               xsint,
	input  wire               dl_active_i,
	input  wire  [ADDR_W-1:0] dl_addr_i,
	input  wire               rom2_sel_i,
	input  wire  [ADDR_W-1:0] cpu_addr_i,
	output logic [ADDR_W-1:0] rom_addr_o
);

	logic tos192k; // set: 192k image at $fc0000

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			tos192k <= 1'b0;
		else if (dl_active_i) begin
			if (dl_addr_i[22:17] == 6'b111111)
				tos192k <= 1'b1; // upload to top of memory
			else if (dl_addr_i[22:19] == 4'hE)
				tos192k <= 1'b0; // 256k image at $e00000
		end
	end

	// bank 2 remap, low 17 word bits kept
	always_comb begin
		if (!rom2_sel_i)
			rom_addr_o = cpu_addr_i;
		else if (tos192k)
			rom_addr_o = {4'hF, 2'b11, cpu_addr_i[16:0]};
		else
			rom_addr_o = {4'hE, 2'b00, cpu_addr_i[16:0]};
	end

endmodule

`default_nettype wire

/* src/st_viking_watch.sv */
// counts only mmu accesses seen on pre slot strobes; active stays set until reset
`timescale 1ns/10ps
`default_nettype none

module st_viking_watch
	import st_mem_pkg::*;
#(
	parameter int VIKING_HITS = 255 // accesses before driver counts as loaded
) (
	input  wire       clk_32,
	input  wire       xsint,
	input  sys_cfg_t  cfg_i,
	input  wire       slot_stb_i,
	input  slot_e     slot_i,
	input  mmu_req_t  mmu_i,
	output logic      viking_active_o
);

	localparam int CNT_W = $clog2(VIKING_HITS + 1);

	logic [CNT_W-1:0] hit_cnt;
	logic [5:0]       win_base;
	logic             hit;
	logic             full;

	assign win_base = cfg_i.steroids ? VIKING_BASE_HI : VIKING_BASE_ST;
	assign full     = (hit_cnt == CNT_W'(VIKING_HITS)); // saturate here

	// probes outside the window are ignored
	assign hit = slot_stb_i && (slot_i == PRE) && (mmu_i.rd || mmu_i.wr) &&
	             cfg_i.viking_en && (mmu_i.addr[22:17] == win_base);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			hit_cnt         <= '0;
			viking_active_o <= 1'b0;
		end else begin
			if (hit && !full)
				hit_cnt <= hit_cnt + CNT_W'(1);
			viking_active_o <= full; // one clock behind the count
		end
	end

	// once the driver is seen the card keeps the video slot
	a_active_sticky: assert property (@(posedge clk_32) disable iff (!xsint)
		viking_active_o |=> viking_active_o);

endmodule

`default_nettype wire

/* src/st_mem_top.sv */
// memory side only; sdram_o feeds an external sdram controller, one command per clock
`timescale 1ns/10ps
`default_nettype none

module st_mem_top
	import st_mem_pkg::*;
#(
	parameter int SLOT_DIV    = 4,
	parameter int VIKING_HITS = 255
) (
	input  wire               clk_32,
	input  wire               xsint,
	input  wire  [31:0]       system_ctrl_i,
	input  mmu_req_t          mmu_i,
	input  bm_req_t           bm_i,
	input  wire               bm_has_bus_i,   // blitter holds bgack
	input  wire  [ADDR_W-1:0] vid_addr_i,
	input  wire               vid_read_i,
	input  wire               rom2_sel_i,
	input  wire  [ADDR_W-1:0] cpu_addr_i,
	input  wire               dl_active_i,    // whole tos upload
	input  wire  [ADDR_W-1:0] dl_addr_i,
	input  wire  [DATA_W-1:0] dl_data_i,
	input  wire               dl_req_i,
	output sdram_cmd_t        sdram_o,
	output logic [ADDR_W-1:0] rom_addr_o,
	output logic              dl_ack_o,
	output slot_e             bus_slot_o,
	output logic              viking_active_o
);

	sys_cfg_t cfg;
	logic     slot_stb;
	owner_e   owner;
	logic     dl_wr;

	st_bus_ctrl #(.SLOT_DIV(SLOT_DIV)) u_bus_ctrl (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.system_ctrl_i   (system_ctrl_i),
		.dl_active_i     (dl_active_i),
		.dl_req_i        (dl_req_i),
		.bm_has_bus_i    (bm_has_bus_i),
		.vid_read_i      (vid_read_i),
		.viking_active_i (viking_active_o),
		.cfg_o           (cfg),
		.slot_o          (bus_slot_o),
		.slot_stb_o      (slot_stb),
		.owner_o         (owner),
		.dl_wr_o         (dl_wr),
		.dl_ack_o        (dl_ack_o)
	);

	st_ram_window u_ram_window (
		.clk_32     (clk_32),
		.xsint      (xsint),
		.cfg_i      (cfg),
		.owner_i    (owner),
		.dl_wr_i    (dl_wr),
		.mmu_i      (mmu_i),
		.bm_i       (bm_i),
		.vid_addr_i (vid_addr_i),
		.dl_addr_i  (dl_addr_i),
		.dl_data_i  (dl_data_i),
		.sdram_o    (sdram_o)
	);

	// watches upload addresses independently of the handshake
	st_rom_map u_rom_map (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.dl_active_i (dl_active_i),
		.dl_addr_i   (dl_addr_i),
		.rom2_sel_i  (rom2_sel_i),
		.cpu_addr_i  (cpu_addr_i),
		.rom_addr_o  (rom_addr_o)
	);

	st_viking_watch #(.VIKING_HITS(VIKING_HITS)) u_viking_watch (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.cfg_i           (cfg),
		.slot_stb_i      (slot_stb),
		.slot_i          (bus_slot_o),
		.mmu_i           (mmu_i),
		.viking_active_o (viking_active_o)
	);

endmodule

`default_nettype wire

/* test/st_mem_checker.sv */
// model of st_mem_top built from the bus rules; expects inputs to change only on rising edges
`timescale 1ns/10ps
`default_nettype none

module st_mem_checker
	import st_mem_pkg::*;
#(
	parameter int SLOT_DIV    = 4,
	parameter int VIKING_HITS = 255
) (
	input  wire               clk_32,
	input  wire               xsint,
	input  wire  [31:0]       system_ctrl_i,
	input  mmu_req_t          mmu_i,
	input  bm_req_t           bm_i,
	input  wire               bm_has_bus_i,
	input  wire  [ADDR_W-1:0] vid_addr_i,
	input  wire               vid_read_i,
	input  wire               rom2_sel_i,
	input  wire  [ADDR_W-1:0] cpu_addr_i,
	input  wire               dl_active_i,
	input  wire  [ADDR_W-1:0] dl_addr_i,
	input  wire  [DATA_W-1:0] dl_data_i,
	input  wire               dl_req_i,
	input  sdram_cmd_t        sdram_i,
	input  wire  [ADDR_W-1:0] rom_addr_i,
	input  wire               dl_ack_i,
	input  slot_e             bus_slot_i,
	input  wire               viking_active_i,
	output int                mismatch_cnt_o,
	output int                protocol_cnt_o
);

	int         mism = 0;
	int         proto = 0;
	int         div;        // clocks into the slot
	int         slot;       // 0 pre .. 3 idle
	int         hits;
	logic       tos_top;    // last upload went to top of memory
	logic       active;
	logic       ack;
	logic       prev_ack;
	logic       prev_req;
	logic       exp_valid;
	sdram_cmd_t exp_q;      // command due one clock later

	assign mismatch_cnt_o = mism;
	assign protocol_cnt_o = proto;

	task automatic report_mismatch(input string name, input logic [63:0] e, input logic [63:0] g);
		mism++;
		$display("mismatch at %0t: %s expected %h got %h", $time, name, e, g);
	endtask

	task automatic report_protocol(input string what);
		proto++;
		$display("protocol error at %0t: %s", $time, what);
	endtask

	always @(posedge clk_32) begin : model_step
		logic [23:0]       byte_a;
		logic [2:0]        size;
		logic              steroids;
		logic              v_en;
		logic              stb;
		logic              in_ram;
		logic              dl_wr;
		logic              hit;
		logic [5:0]        base;
		logic [ADDR_W-1:0] rom_exp;
		sdram_cmd_t        cmd;
		if (!xsint) begin
			div       <= 0;
			slot      <= 0;
			hits      <= 0;
			tos_top   <= 1'b0;
			active    <= 1'b0;
			ack       <= 1'b0;
			prev_ack  <= 1'b0;
			prev_req  <= 1'b0;
			exp_valid <= 1'b0;
		end else begin
			size     = system_ctrl_i[3:1];
			steroids = system_ctrl_i[23] && system_ctrl_i[24];
			v_en     = steroids || (system_ctrl_i[28] && size <= 3'd4);
			stb      = (div == SLOT_DIV - 1);
			byte_a   = {mmu_i.addr, 1'b0};
			case (size)
				3'd0: in_ram = byte_a < 24'h080000;
				3'd1: in_ram = byte_a < 24'h100000;
				3'd2: in_ram = byte_a < 24'h200000;
				3'd3: in_ram = byte_a < 24'h400000;
				3'd4: in_ram = byte_a < 24'h800000;
				3'd5: in_ram = byte_a < 24'hE00000; // 14M stops below rom/io
				default: in_ram = 1'b0;
			endcase
			dl_wr = dl_active_i && dl_req_i && !ack && slot == 1 && stb;
			cmd = '{addr: {1'b0, mmu_i.addr}, din: mmu_i.data, oe: mmu_i.rd && in_ram,
			        we: mmu_i.wr && in_ram, uds: mmu_i.uds, lds: mmu_i.lds};
			if (slot == 1 && dl_active_i)
				cmd = '{addr: {1'b0, dl_addr_i}, din: dl_data_i, oe: 1'b0, we: dl_wr,
				        uds: 1'b1, lds: 1'b1};
			else if (slot == 1 && bm_has_bus_i)
				cmd = '{addr: {1'b0, bm_i.addr}, din: bm_i.data, oe: bm_i.rd, we: bm_i.wr,
				        uds: 1'b1, lds: 1'b1};
			else if (slot == 2 && active && vid_read_i)
				cmd = '{addr: {1'b0, vid_addr_i}, din: 16'h0, oe: 1'b1, we: 1'b0,
				        uds: 1'b1, lds: 1'b1};
			base = steroids ? 6'b111010 : 6'b110000; // $e80000 or $c00000
			hit  = stb && slot == 0 && (mmu_i.rd || mmu_i.wr) && v_en &&
			       mmu_i.addr[22:17] == base;
			if (!rom2_sel_i)
				rom_exp = cpu_addr_i;
			else
				rom_exp = tos_top ? {6'b111111, cpu_addr_i[16:0]} : {6'b111000, cpu_addr_i[16:0]};

			// compare what the dut shows for the cycle just ended
			if (exp_valid && sdram_i !== exp_q)
				report_mismatch("sdram_o", 64'(exp_q), 64'(sdram_i));
			if (rom_addr_i !== rom_exp)
				report_mismatch("rom_addr_o", 64'(rom_exp), 64'(rom_addr_i));
			if (dl_ack_i !== ack)
				report_mismatch("dl_ack_o", 64'(ack), 64'(dl_ack_i));
			if (viking_active_i !== active)
				report_mismatch("viking_active_o", 64'(active), 64'(viking_active_i));
			if (bus_slot_i !== slot_e'(slot))
				report_mismatch("bus_slot_o", 64'(slot), 64'(bus_slot_i));
			if (dl_ack_i && !prev_ack && !prev_req)
				report_protocol("upload acknowledge rose with no request pending");
			if (!dl_ack_i && prev_ack && prev_req)
				report_protocol("upload acknowledge dropped while the request was still high");

			// advance the model
			exp_q     <= cmd;
			exp_valid <= 1'b1;
			prev_ack  <= dl_ack_i;
			prev_req  <= dl_req_i;
			if (dl_wr)
				ack <= 1'b1;
			else if (ack && !dl_req_i)
				ack <= 1'b0;
			div  <= stb ? 0 : div + 1;
			slot <= stb ? (slot + 1) % 4 : slot;
			if (dl_active_i && {dl_addr_i, 1'b0} >= 24'hFC0000)
				tos_top <= 1'b1; // 192k image
			else if (dl_active_i && dl_addr_i[22:19] == 4'hE)
				tos_top <= 1'b0;
			if (hit && hits < VIKING_HITS)
				hits <= hits + 1;
			active <= (hits == VIKING_HITS);
		end
	end

endmodule

`default_nettype wire

/* test/tb_st_mem.sv */
// drives st_mem_top from a fixed xorshift seed; needs a simulator with timing support (#, @ in tasks)
`timescale 1ns/10ps
`default_nettype none

module tb_st_mem
	import st_mem_pkg::*;
();

	localparam int SLOT_DIV    = 4;
	localparam int HITS        = 8;  // short hi-res detect phase
	localparam int SIZE_CYCLES = 200;
	localparam int UPLOADS     = 24;
	localparam int UPLOAD_MAX  = 4 * SLOT_DIV + 8; // worst case per req/ack round
	localparam int BLIT_CYCLES = 400;
	localparam int VIK_CYCLES  = 400;
	localparam int RUN_CYCLES  = 8 + 6 * SIZE_CYCLES + UPLOADS * UPLOAD_MAX + BLIT_CYCLES +
	                             2 * (8 + VIK_CYCLES) + 8;
	localparam int MAX_CYCLES  = RUN_CYCLES + 200;

	logic              clk_32 = 1'b0;
	logic              xsint;
	logic [31:0]       system_ctrl;
	mmu_req_t          mmu;
	bm_req_t           bm;
	logic              bm_has_bus;
	logic [ADDR_W-1:0] vid_addr;
	logic              vid_read;
	logic              rom2_sel;
	logic [ADDR_W-1:0] cpu_addr;
	logic              dl_active;
	logic [ADDR_W-1:0] dl_addr;
	logic [DATA_W-1:0] dl_data;
	logic              dl_req;
	sdram_cmd_t        sdram;
	logic [ADDR_W-1:0] rom_addr;
	logic              dl_ack;
	slot_e             bus_slot;
	logic              viking_active;
	int                mismatches;
	int                protocol_errs;

	logic [31:0] rng = 32'd16; // xorshift state
	logic [31:0] ctrl_word;    // control word for the running phase
	logic        win_mode;     // aim most mmu pulses at the hi-res window
	logic        blit_mode;
	int          pre_run;      // finished cycles of the current pre slot
	int          cycles = 0;

	always #50 clk_32 = ~clk_32;

	st_mem_top #(.SLOT_DIV(SLOT_DIV), .VIKING_HITS(HITS)) dut0 (
		.clk_32(clk_32), .xsint(xsint), .system_ctrl_i(system_ctrl), .mmu_i(mmu), .bm_i(bm),
		.bm_has_bus_i(bm_has_bus), .vid_addr_i(vid_addr), .vid_read_i(vid_read),
		.rom2_sel_i(rom2_sel), .cpu_addr_i(cpu_addr), .dl_active_i(dl_active),
		.dl_addr_i(dl_addr), .dl_data_i(dl_data), .dl_req_i(dl_req), .sdram_o(sdram),
		.rom_addr_o(rom_addr), .dl_ack_o(dl_ack), .bus_slot_o(bus_slot),
		.viking_active_o(viking_active)
	);

	st_mem_checker #(.SLOT_DIV(SLOT_DIV), .VIKING_HITS(HITS)) checker0 (
		.clk_32(clk_32), .xsint(xsint), .system_ctrl_i(system_ctrl), .mmu_i(mmu), .bm_i(bm),
		.bm_has_bus_i(bm_has_bus), .vid_addr_i(vid_addr), .vid_read_i(vid_read),
		.rom2_sel_i(rom2_sel), .cpu_addr_i(cpu_addr), .dl_active_i(dl_active),
		.dl_addr_i(dl_addr), .dl_data_i(dl_data), .dl_req_i(dl_req), .sdram_i(sdram),
		.rom_addr_i(rom_addr), .dl_ack_i(dl_ack), .bus_slot_i(bus_slot),
		.viking_active_i(viking_active), .mismatch_cnt_o(mismatches),
		.protocol_cnt_o(protocol_errs)
	);

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// one clock of random stimulus with mmu pulses only on the pre slot strobe
	task automatic drive_cycle();
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		logic        pulse;
		@(posedge clk_32);
		pre_run = (!xsint || bus_slot != PRE) ? 0 : pre_run + 1;
		pulse   = (pre_run == SLOT_DIV - 1); // next cycle is the last pre cycle
		r0 = next_rand();
		r1 = next_rand();
		r2 = next_rand();
		r3 = next_rand();
		if (win_mode && (r1[0] || r1[8]))
			r0[22:17] = (ctrl_word[23] && ctrl_word[24]) ? VIKING_BASE_HI : VIKING_BASE_ST;
		else if (!win_mode)
			r0 = r0 >> r1[9:7]; // spread over the small ram sizes too
		system_ctrl <= ctrl_word;
		mmu <= '{addr: r0[22:0], data: r1[31:16], rd: pulse && r1[1], wr: pulse && !r1[1],
		         uds: r1[2], lds: r1[3]};
		bm <= '{addr: r2[22:0], data: r3[15:0], rd: r3[16], wr: !r3[16] && r3[17]};
		bm_has_bus <= blit_mode && r3[18];
		vid_read   <= r1[4];
		rom2_sel   <= r1[5];
		vid_addr   <= ADDR_W'(next_rand() >> 9);
		cpu_addr   <= ADDR_W'(next_rand() >> 9);
	endtask

	task automatic run_cycles(input int n);
		repeat (n) drive_cycle();
	endtask

	task automatic pulse_reset();
		xsint <= 1'b0;
		run_cycles(8);
		xsint <= 1'b1;
	endtask

	// one four-phase req/ack round
	task automatic upload_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		drive_cycle();
		dl_addr <= a;
		dl_data <= d;
		dl_req  <= 1'b1;
		while (dl_ack !== 1'b1)
			drive_cycle();
		dl_req <= 1'b0;
		while (dl_ack !== 1'b0)
			drive_cycle();
	endtask

	task automatic print_counts();
		$display("errors: %0d mismatches, %0d protocol", mismatches, protocol_errs);
	endtask

	always @(posedge clk_32) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			print_counts();
			$display("Something failed");
			$finish;
		end
	end

	initial begin : main
		logic [31:0] a;
		logic [31:0] d;
		xsint = 1'b0;
		{system_ctrl, mmu, bm, bm_has_bus, vid_addr, vid_read} = '0;
		{rom2_sel, cpu_addr, dl_active, dl_addr, dl_data, dl_req} = '0;
		ctrl_word = '0;
		win_mode  = 1'b0;
		blit_mode = 1'b0;
		pre_run   = 0;
		pulse_reset();
		for (int s = 0; s < 6; s++) begin // every ram size without the hi-res card
			ctrl_word = (next_rand() & 32'hEE7F_FFF1) | (32'(s) << 1);
			run_cycles(SIZE_CYCLES);
		end
		ctrl_word = 32'h0000_000A; // 14M
		blit_mode = 1'b1;          // blitter competes with the upload
		drive_cycle();
		dl_active <= 1'b1;
		for (int i = 0; i < UPLOADS; i++) begin
			a = next_rand();
			d = next_rand();
			if (i % 3 == 0)
				a[22:19] = 4'hE;  // 256k tos region
			else if (i % 3 == 1)
				a[22:17] = 6'h3F; // top of memory
			upload_word(a[22:0], d[15:0]);
		end
		drive_cycle();
		dl_active <= 1'b0;
		run_cycles(BLIT_CYCLES);
		blit_mode = 1'b0;
		win_mode  = 1'b1;
		ctrl_word = 32'h1000_0006; // 4M with the card enabled
		run_cycles(VIK_CYCLES);
		pulse_reset();             // detection is sticky until reset
		ctrl_word = 32'h0180_000A; // steroids at 14M
		run_cycles(VIK_CYCLES);
		run_cycles(3);             // last command reaches the checker
		print_counts();
		if (mismatches == 0 && protocol_errs == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
src/st_mem_pkg.sv
src/st_bus_ctrl.sv
src/st_ram_window.sv
src/st_rom_map.sv
src/st_viking_watch.sv
src/st_mem_top.sv
test/st_mem_checker.sv
test/tb_st_mem.sv

/* Makefile */
# Verilator build for the st_mem_top testbench
VERILATOR ?= verilator
TOP       ?= tb_st_mem
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
